// ==== verif/tiny_soc_golden.txt ====
# H n is a random host write and read back of n words. P addr w0 w1 w2 w3 writes four words.
# R addr n value resets and runs the core while the host polls n words for value; E addr value; S halted error.
H 16
# Arithmetic program with logic, shifts, a BNE loop, JAL, JALR, LW and EBREAK.
P 000 40000513 06400093 FF900113 002081B3
P 004 40208233 123452B7 0022C333 001373B3
P 008 0033E433 00400593 00B294B3 00B35633
P 00C 00352023 00452223 00552423 00652623
P 010 00752823 00852A23 00952C23 00C52E23
P 014 00000693 00500713 00E686B3 FFF70713
P 018 FE071CE3 02D52023 008007EF 00000793
P 01C 01078867 00000813 00000793 02F52223
P 020 03052423 00052883 03152623 00100073
R 000 0 00000000
E 100 0000005D
E 101 0000006B
E 102 12345000
E 103 EDCBAFF9
E 104 00000060
E 105 0000007D
E 106 23450000
E 107 0EDCBAFF
E 108 0000000F
E 109 0000006C
E 10A 00000074
E 10B 0000005D
S 1 0
# Divide program with DIVU and REMU, including a zero divisor.
P 000 48000513 3E800093 00700113 0220D1B3
P 004 0220F233 0200D2B3 0200F333 FFF00393
P 008 01000413 0283D4B3 0283F5B3 00352023
P 00C 00452223 00552423 00652623 00952823
P 010 00B52A23 00100073 00000013 00000013
R 000 0 00000000
E 120 0000008E
E 121 00000006
E 122 FFFFFFFF
E 123 000003E8
E 124 0FFFFFFF
E 125 0000000F
S 1 0
# Load loop over a constant region that the host polls during the run.
P 140 01010101 01010101 01010101 01010101
P 000 50000513 00400593 00000613 00052683
P 004 00D60633 00450513 FFF58593 FE0598E3
P 008 02C52823 02D52A23 00100073 00000013
R 140 4 01010101
E 150 04040404
E 151 01010101
S 1 0
# Store, then a JALR to a misaligned target.
P 160 00000000 00000000 00000000 00000000
P 000 58000513 05A00093 00152023 02200113
P 004 00010067 00152223 00100073 00000013
R 000 0 00000000
E 160 0000005A
E 161 00000000
S 0 1

// ==== tiny_soc.f ====
design/tiny_soc_pkg.sv
design/rv_decoder.sv
design/rv_divider.sv
design/rv_core.sv
design/bus_arbiter.sv
design/data_sram.sv
design/tiny_soc.sv
verif/tiny_soc_asserts.sv
verif/tiny_soc_tb.sv

// ==== Bender.yml ====
package:
  name: tiny_soc

sources:
  - design/tiny_soc_pkg.sv
  - design/rv_decoder.sv
  - design/rv_divider.sv
  - design/rv_core.sv
  - design/bus_arbiter.sv
  - design/data_sram.sv
  - design/tiny_soc.sv
  - target: test
    files:
      - verif/tiny_soc_asserts.sv
      - verif/tiny_soc_tb.sv

// ==== verif/tiny_soc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiny_soc_tb
    import tiny_soc_pkg::*;
;
    logic main_clk;
    logic nreset;
    logic run;
    logic halted;
    logic error;
    logic host_valid;
    logic host_ready;
    word_t host_addr;
    word_t host_wdata;
    logic host_we;
    word_t host_rdata;

    word_t rand_state;
    int unsigned cycle_count;
    int data_errors;
    int status_errors;
    int other_errors;
    int unsigned assert_failures;
    logic timed_out;
    int fd;
    string line;

    tiny_soc i_tiny_soc (
        .main_clk   (main_clk),
        .nreset     (nreset),
        .run        (run),
        .halted     (halted),
        .error      (error),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata)
    );

    always #2 main_clk = ~main_clk;

    always @(posedge main_clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic word_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check_word(input word_t addr, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("[ERROR] host_rdata at word 0x%h: got 0x%h, expected 0x%h",
                     addr, got, expected);
            data_errors++;
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] expected);
        if (got !== expected) begin
            $display("[ERROR] {halted, error}: got 0x%h, expected 0x%h", got, expected);
            status_errors++;
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge main_clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        nreset = 1'b0;
        repeat (3) begin
            @(posedge main_clk);
        end
        #1;
        nreset = 1'b1;
    endtask

    // Tasks start 1 ns after a rising edge; ready is sampled at that point too.
    task automatic host_write(input word_t addr, input word_t data);
        int waited;
        host_valid = 1'b1;
        host_we = 1'b1;
        host_addr = addr;
        host_wdata = data;
        waited = 0;
        do begin
            @(posedge main_clk);
            #1;
            waited++;
        end while (!host_ready && waited < 200);
        if (!host_ready) begin
            $display("Host write to word 0x%h got no ready within 200 cycles", addr);
            other_errors++;
            timed_out = 1'b1;
        end
        @(posedge main_clk);
        #1;
        host_valid = 1'b0;
        host_we = 1'b0;
    endtask

    task automatic host_read(input word_t addr, output word_t data);
        int waited;
        host_valid = 1'b1;
        host_we = 1'b0;
        host_addr = addr;
        waited = 0;
        do begin
            @(posedge main_clk);
            #1;
            waited++;
        end while (!host_ready && waited < 200);
        data = host_rdata;
        if (!host_ready) begin
            $display("Host read of word 0x%h got no ready within 200 cycles", addr);
            other_errors++;
            timed_out = 1'b1;
        end
        @(posedge main_clk);
        #1;
        host_valid = 1'b0;
    endtask

    // Each batch address keeps its index in the low five bits, so no two collide.
    task automatic random_host_test(input int count);
        word_t addrs [32];
        word_t datas [32];
        word_t got;
        int n;
        n = (count > 32) ? 32 : count;
        for (int i = 0; i < n && !timed_out; i++) begin
            addrs[i] = ((next_rand() >> 8) % (mem_words / 32)) * 32 + i;
            datas[i] = next_rand();
            host_write(addrs[i], datas[i]);
        end
        for (int i = 0; i < n && !timed_out; i++) begin
            idle_cycles(next_rand() >> 29);
            host_read(addrs[i], got);
            if (!timed_out) begin
                check_word(addrs[i], got, datas[i]);
            end
        end
    endtask

    task automatic run_program(input word_t region, input int count, input word_t value);
        int unsigned start;
        int idx;
        word_t got;
        apply_reset();
        run = 1'b1;
        start = cycle_count;
        idx = 0;
        while (!halted && !error && !timed_out) begin
            if (cycle_count - start >= 20000) begin
                $display("Core neither halted nor raised error within 20000 cycles");
                other_errors++;
                timed_out = 1'b1;
            end else if (count > 0) begin
                host_read(region + idx, got);
                if (!timed_out) begin
                    check_word(region + idx, got, value);
                end
                idx = (idx + 1) % count;
                idle_cycles(next_rand() >> 29);
            end else begin
                idle_cycles(1);
            end
        end
        run = 1'b0;
    endtask

    task automatic process_line(input string text);
        byte kind;
        logic ok;
        word_t addr;
        word_t words [4];
        word_t value;
        word_t got;
        int count;
        int exp_halted;
        int exp_error;
        ok = 1'b1;
        kind = text.getc(0);
        case (kind)
            "H": begin
                ok = $sscanf(text, "H %d", count) == 1;
                if (ok) begin
                    random_host_test(count);
                end
            end
            "P": begin
                ok = $sscanf(text, "P %h %h %h %h %h",
                             addr, words[0], words[1], words[2], words[3]) == 5;
                for (int i = 0; i < 4 && ok && !timed_out; i++) begin
                    host_write(addr + i, words[i]);
                end
            end
            "R": begin
                ok = $sscanf(text, "R %h %d %h", addr, count, value) == 3;
                if (ok) begin
                    run_program(addr, count, value);
                end
            end
            "E": begin
                ok = $sscanf(text, "E %h %h", addr, value) == 2;
                if (ok) begin
                    host_read(addr, got);
                    if (!timed_out) begin
                        check_word(addr, got, value);
                    end
                end
            end
            "S": begin
                ok = $sscanf(text, "S %d %d", exp_halted, exp_error) == 2;
                if (ok) begin
                    check_status({halted, error}, {exp_halted[0], exp_error[0]});
                end
            end
            "#", 8'h0a, 8'h0d, 8'h00: ok = 1'b1;
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            $display("Golden file line could not be parsed: %s", text);
            other_errors++;
        end
    endtask

    initial begin
        main_clk = 1'b0;
        nreset = 1'b0;
        run = 1'b0;
        host_valid = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        rand_state = 32'h4ac0;
        cycle_count = 0;
        data_errors = 0;
        status_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;

        apply_reset();
        fd = $fopen("verif/tiny_soc_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/tiny_soc_golden.txt for reading");
            other_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(line, fd) > 0) begin
                    process_line(line);
                end
            end
            $fclose(fd);
        end
        idle_cycles(2);

        assert_failures = i_tiny_soc.i_bus_arbiter.i_tiny_soc_asserts.fail_count;
        $display("Summary: %0d word, %0d status, %0d other, %0d assertion failures",
                 data_errors, status_errors, other_errors, assert_failures);
        if (data_errors == 0 && status_errors == 0 && other_errors == 0
                && assert_failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tiny_soc_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiny_soc_asserts
    import tiny_soc_pkg::*;
(
    input logic  main_clk,
    input logic  nreset,
    input logic  core_valid,
    input logic  core_ready,
    input word_t core_addr,
    input word_t core_wdata,
    input logic  core_we,
    input logic  host_valid,
    input logic  host_ready,
    input word_t host_addr,
    input word_t host_wdata,
    input logic  host_we,
    input logic  mem_ready
);
    int unsigned fail_count = 0;

    core_valid_held: assert property (@(posedge main_clk) disable iff (!nreset)
        core_valid && !core_ready |=> core_valid)
    else begin
        fail_count++;
        $error("core_valid dropped before core_ready");
    end

    host_valid_held: assert property (@(posedge main_clk) disable iff (!nreset)
        host_valid && !host_ready |=> host_valid)
    else begin
        fail_count++;
        $error("host_valid dropped before host_ready");
    end

    // A waiting request must not change under the arbiter.
    core_req_stable: assert property (@(posedge main_clk) disable iff (!nreset)
        core_valid && !core_ready |=>
            $stable(core_addr) && $stable(core_wdata) && $stable(core_we))
    else begin
        fail_count++;
        $error("core request changed while waiting for core_ready");
    end

    host_req_stable: assert property (@(posedge main_clk) disable iff (!nreset)
        host_valid && !host_ready |=>
            $stable(host_addr) && $stable(host_wdata) && $stable(host_we))
    else begin
        fail_count++;
        $error("host request changed while waiting for host_ready");
    end

    mem_ready_single: assert property (@(posedge main_clk) disable iff (!nreset)
        mem_ready |=> !mem_ready)
    else begin
        fail_count++;
        $error("mem_ready was high in two consecutive cycles");
    end

endmodule

bind bus_arbiter tiny_soc_asserts i_tiny_soc_asserts (
    .main_clk   (main_clk),
    .nreset     (nreset),
    .core_valid (core_valid),
    .core_ready (core_ready),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_we    (core_we),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_we    (host_we),
    .mem_ready  (mem_ready)
);

`default_nettype wire

// ==== design/tiny_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module tiny_soc
    import tiny_soc_pkg::*;
(
    input  logic  main_clk,
    input  logic  nreset,
    input  logic  run,
    output logic  halted,
    output logic  error,
    input  logic  host_valid,
    output logic  host_ready,
    input  word_t host_addr,
    input  word_t host_wdata,
    input  logic  host_we,
    output word_t host_rdata
);
    logic core_valid;
    logic core_ready;
    word_t core_addr;
    word_t core_wdata;
    logic core_we;
    word_t core_rdata;
    logic mem_valid;
    logic mem_ready;
    logic [mem_addr_bits-1:0] mem_addr;
    word_t mem_wdata;
    logic mem_we;
    word_t mem_rdata;

    rv_core i_rv_core (
        .main_clk  (main_clk),
        .nreset    (nreset),
        .run       (run),
        .halted    (halted),
        .error     (error),
        .mem_valid (core_valid),
        .mem_ready (core_ready),
        .mem_addr  (core_addr),
        .mem_wdata (core_wdata),
        .mem_we    (core_we),
        .mem_rdata (core_rdata)
    );

    bus_arbiter i_bus_arbiter (
        .main_clk   (main_clk),
        .nreset     (nreset),
        .core_valid (core_valid),
        .core_ready (core_ready),
        .core_addr  (core_addr),
        .core_wdata (core_wdata),
        .core_we    (core_we),
        .core_rdata (core_rdata),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata)
    );

    data_sram i_data_sram (
        .main_clk  (main_clk),
        .nreset    (nreset),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== design/data_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_sram
    import tiny_soc_pkg::*;
(
    input  logic  main_clk,
    input  logic  nreset,
    input  logic  mem_valid,
    output logic  mem_ready,
    input  logic [mem_addr_bits-1:0] mem_addr,
    input  word_t mem_wdata,
    input  logic  mem_we,
    output word_t mem_rdata
);
    word_t mem [mem_words];
    logic accept;

    // A request still held high during its ready cycle is not taken twice.
    assign accept = mem_valid && !mem_ready;

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= accept;
        end
    end

    always_ff @(posedge main_clk) begin
        if (accept) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
    import tiny_soc_pkg::*;
(
    input  logic  main_clk,
    input  logic  nreset,
    input  logic  core_valid,
    output logic  core_ready,
    input  word_t core_addr,
    input  word_t core_wdata,
    input  logic  core_we,
    output word_t core_rdata,
    input  logic  host_valid,
    output logic  host_ready,
    input  word_t host_addr,
    input  word_t host_wdata,
    input  logic  host_we,
    output word_t host_rdata,
    output logic  mem_valid,
    input  logic  mem_ready,
    output logic [mem_addr_bits-1:0] mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    input  word_t mem_rdata
);
    logic open_xfer;
    logic last_host;
    logic pick_host;
    logic sel_host;

    // With both masters requesting, the one not served last wins.
    assign pick_host = host_valid && (!core_valid || !last_host);
    assign sel_host = open_xfer ? last_host : pick_host;

    assign mem_valid = sel_host ? host_valid : core_valid;
    assign mem_addr = sel_host ? host_addr[mem_addr_bits-1:0] : core_addr[mem_addr_bits+1:2];
    assign mem_wdata = sel_host ? host_wdata : core_wdata;
    assign mem_we = sel_host ? host_we : core_we;

    assign core_ready = mem_ready && !sel_host;
    assign host_ready = mem_ready && sel_host;
    assign core_rdata = sel_host ? '0 : mem_rdata;
    assign host_rdata = sel_host ? mem_rdata : '0;

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            open_xfer <= 1'b0;
            last_host <= 1'b1;
        end else if (mem_ready) begin
            open_xfer <= 1'b0;
        end else if (mem_valid && !open_xfer) begin
            open_xfer <= 1'b1;
            last_host <= pick_host;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core
    import tiny_soc_pkg::*;
(
    input  logic  main_clk,
    input  logic  nreset,
    input  logic  run,
    output logic  halted,
    output logic  error,
    output logic  mem_valid,
    input  logic  mem_ready,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    input  word_t mem_rdata
);
    logic [1:0] stage;
    word_t pc;
    word_t instr;
    word_t rs1_val;
    word_t rs2_val;
    word_t alu_result;
    word_t next_pc;
    logic req_hold;
    word_t regs [32];

    alu_op_t alu_op;
    op2_src_t op2_src;
    wb_src_t wb_src;
    br_cond_t br_cond;
    logic reg_we;
    logic mem_load;
    logic mem_store;
    logic is_jalr;
    logic halt;
    logic illegal;
    word_t imm;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;

    logic div_start;
    logic div_busy;
    logic div_done;
    word_t div_quotient;
    word_t div_remainder;

    word_t op_b;
    word_t alu_out;
    word_t pc_plus4;
    word_t target;
    word_t wb_data;
    logic take_branch;
    logic is_div;
    logic mem_op;
    logic want_req;
    logic retire;

    rv_decoder i_rv_decoder (
        .instr     (instr),
        .alu_op    (alu_op),
        .op2_src   (op2_src),
        .wb_src    (wb_src),
        .reg_we    (reg_we),
        .mem_load  (mem_load),
        .mem_store (mem_store),
        .is_jalr   (is_jalr),
        .halt      (halt),
        .illegal   (illegal),
        .br_cond   (br_cond),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd)
    );

    rv_divider i_rv_divider (
        .main_clk  (main_clk),
        .nreset    (nreset),
        .start     (div_start),
        .dividend  (rs1_val),
        .divisor   (rs2_val),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    assign pc_plus4 = pc + 32'd4;
    assign op_b = (op2_src == op2_imm) ? imm : rs2_val;
    assign is_div = (alu_op == alu_divu) || (alu_op == alu_remu);
    assign mem_op = mem_load || mem_store;
    assign target = is_jalr ? (alu_out & ~32'd1) : pc + imm;

    always_comb begin
        case (alu_op)
            alu_sub: alu_out = rs1_val - op_b;
            alu_and: alu_out = rs1_val & op_b;
            alu_or: alu_out = rs1_val | op_b;
            alu_xor: alu_out = rs1_val ^ op_b;
            alu_sll: alu_out = rs1_val << op_b[4:0];
            alu_srl: alu_out = rs1_val >> op_b[4:0];
            alu_pass_b: alu_out = op_b;
            default: alu_out = rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (br_cond)
            br_eq: take_branch = rs1_val == rs2_val;
            br_ne: take_branch = rs1_val != rs2_val;
            br_lt: take_branch = $signed(rs1_val) < $signed(rs2_val);
            br_always: take_branch = 1'b1;
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (wb_src)
            wb_load: wb_data = mem_rdata;
            wb_pc_plus4: wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // Once raised, a request is held through req_hold even if run drops.
    assign want_req = (stage == 2'd0 && pc[1:0] == 2'b00) || (stage == 2'd3 && mem_op);
    assign mem_valid = !halted && !error && (req_hold || (run && want_req));
    assign mem_addr = (stage == 2'd3) ? alu_result : pc;
    assign mem_wdata = rs2_val;
    assign mem_we = (stage == 2'd3) && mem_store;

    assign div_start = run && stage == 2'd2 && is_div && !div_busy && !div_done;
    assign retire = (stage == 2'd3) && (mem_op ? mem_ready : run);

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            stage <= 2'd0;
            pc <= reset_pc;
            halted <= 1'b0;
            error <= 1'b0;
            req_hold <= 1'b0;
        end else begin
            if (mem_ready) begin
                req_hold <= 1'b0;
            end else if (mem_valid) begin
                req_hold <= 1'b1;
            end
            case (stage)
                2'd0: begin
                    if (run && !halted && !error && pc[1:0] != 2'b00) begin
                        error <= 1'b1;
                    end else if (mem_ready) begin
                        stage <= 2'd1;
                    end
                end
                2'd1: begin
                    if (run) begin
                        stage <= 2'd2;
                    end
                end
                2'd2: begin
                    if (div_done) begin
                        stage <= 2'd3;
                    end else if (run && illegal) begin
                        error <= 1'b1;
                    end else if (run && halt) begin
                        halted <= 1'b1;
                    end else if (run && !is_div) begin
                        stage <= 2'd3;
                    end
                end
                default: begin
                    if (retire) begin
                        stage <= 2'd0;
                        pc <= next_pc;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge main_clk) begin
        if (stage == 2'd0 && mem_ready) begin
            instr <= mem_rdata;
        end
        if (stage == 2'd1) begin
            rs1_val <= (rs1 == 5'd0) ? '0 : regs[rs1];
            rs2_val <= (rs2 == 5'd0) ? '0 : regs[rs2];
        end
        if (stage == 2'd2) begin
            if (div_done) begin
                alu_result <= (alu_op == alu_remu) ? div_remainder : div_quotient;
            end else begin
                alu_result <= alu_out;
            end
            next_pc <= take_branch ? target : pc_plus4;
        end
        if (retire && reg_we && rd != 5'd0) begin
            regs[rd] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_divider
    import tiny_soc_pkg::*;
(
    input  logic  main_clk,
    input  logic  nreset,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output logic  busy,
    output logic  done,
    output word_t quotient,
    output word_t remainder
);
    logic [5:0] count;
    word_t divisor_r;
    logic [xlen:0] partial;
    logic [xlen:0] diff;
    logic fits;

    // Shift the next dividend bit into the running remainder.
    assign partial = {remainder, quotient[xlen-1]};
    assign diff = partial - {1'b0, divisor_r};
    assign fits = partial >= {1'b0, divisor_r};

    always_ff @(posedge main_clk) begin
        if (!nreset) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= 6'd0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                if (count == 6'd32) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    count <= count + 6'd1;
                end
            end else if (start) begin
                busy <= 1'b1;
                count <= 6'd0;
            end
        end
    end

    // A zero divisor always fits, so the quotient fills with ones and the
    // remainder ends up holding the dividend.
    always_ff @(posedge main_clk) begin
        if (!busy && start) begin
            quotient <= dividend;
            remainder <= '0;
            divisor_r <= divisor;
        end else if (busy && count != 6'd32) begin
            quotient <= {quotient[xlen-2:0], fits};
            remainder <= fits ? diff[xlen-1:0] : partial[xlen-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decoder
    import tiny_soc_pkg::*;
(
    input  word_t    instr,
    output alu_op_t  alu_op,
    output op2_src_t op2_src,
    output wb_src_t  wb_src,
    output logic     reg_we,
    output logic     mem_load,
    output logic     mem_store,
    output logic     is_jalr,
    output logic     halt,
    output logic     illegal,
    output br_cond_t br_cond,
    output word_t    imm,
    output logic [4:0] rs1,
    output logic [4:0] rs2,
    output logic [4:0] rd
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op = alu_add;
        op2_src = op2_reg;
        wb_src = wb_alu;
        reg_we = 1'b0;
        mem_load = 1'b0;
        mem_store = 1'b0;
        is_jalr = 1'b0;
        halt = 1'b0;
        illegal = 1'b0;
        br_cond = br_none;
        imm = imm_i;
        case (instr[6:0])
            opc_lui: begin
                alu_op = alu_pass_b;
                op2_src = op2_imm;
                imm = imm_u;
                reg_we = 1'b1;
            end
            opc_jal: begin
                br_cond = br_always;
                wb_src = wb_pc_plus4;
                imm = imm_j;
                reg_we = 1'b1;
            end
            opc_jalr: begin
                // The ALU forms rs1 + imm, which becomes the jump target.
                op2_src = op2_imm;
                is_jalr = 1'b1;
                br_cond = br_always;
                wb_src = wb_pc_plus4;
                reg_we = funct3 == 3'b000;
                illegal = funct3 != 3'b000;
            end
            opc_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000: br_cond = br_eq;
                    3'b001: br_cond = br_ne;
                    3'b100: br_cond = br_lt;
                    default: illegal = 1'b1;
                endcase
            end
            opc_load: begin
                op2_src = op2_imm;
                wb_src = wb_load;
                mem_load = funct3 == 3'b010;
                reg_we = funct3 == 3'b010;
                illegal = funct3 != 3'b010;
            end
            opc_store: begin
                op2_src = op2_imm;
                imm = imm_s;
                mem_store = funct3 == 3'b010;
                illegal = funct3 != 3'b010;
            end
            opc_op_imm: begin
                op2_src = op2_imm;
                reg_we = funct3 == 3'b000;
                illegal = funct3 != 3'b000;
            end
            opc_op: begin
                reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_add;
                    {7'b0100000, 3'b000}: alu_op = alu_sub;
                    {7'b0000000, 3'b111}: alu_op = alu_and;
                    {7'b0000000, 3'b110}: alu_op = alu_or;
                    {7'b0000000, 3'b100}: alu_op = alu_xor;
                    {7'b0000000, 3'b001}: alu_op = alu_sll;
                    {7'b0000000, 3'b101}: alu_op = alu_srl;
                    {7'b0000001, 3'b101}: alu_op = alu_divu;
                    {7'b0000001, 3'b111}: alu_op = alu_remu;
                    default: begin
                        reg_we = 1'b0;
                        illegal = 1'b1;
                    end
                endcase
            end
            opc_system: begin
                halt = instr == 32'h0010_0073;
                illegal = instr != 32'h0010_0073;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/tiny_soc_pkg.sv ====
`default_nettype none

package tiny_soc_pkg;

    localparam int xlen = 32;
    localparam int mem_words = 1024;
    localparam int mem_addr_bits = 10;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    typedef logic [xlen-1:0] word_t;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_pass_b,
        alu_divu,
        alu_remu
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc_plus4
    } wb_src_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_always
    } br_cond_t;

    typedef enum logic {
        op2_reg,
        op2_imm
    } op2_src_t;

endpackage

`default_nettype wire
